/* rtl/warp_defs.svh */
`ifndef WARP_DEFS_SVH
`define WARP_DEFS_SVH

// word address bits A[23:1] of the 68000 bus
`define WARP_ADDR_W 23

// active cycles a sound RAM write is held back
`define WARP_TMO_A 8

// active cycles before an unanswered cycle gets BERR
`define WARP_TMO_B 64

// cycle counter width, must hold WARP_TMO_B
`define WARP_CNT_W 7

`endif

/* rtl/fsbPkg.sv */
`include "warp_defs.svh"

package fsbPkg;

	// word address, byte address is this shifted left by one
	typedef logic [`WARP_ADDR_W-1:0] fsbAddr_t;

	// bus inputs of the accelerated CPU, strobes active low
	typedef struct packed {
		fsbAddr_t addr;
		logic nAs;
		logic nLds;
		logic nUds;
		logic nWe;
	} fsbCycle_t;

endpackage

/* rtl/ctlPkg.sv */
package ctlPkg;

	// one select bit per decoded region
	typedef struct packed {
		logic ramCs;
		logic romCs;
		logic scsiCs;
		logic ioCs;
		logic iaCs;
		logic sndWrCs;
	} devSel_t;

	// I/O bus slave port states
	typedef enum logic [1:0] {
		IO_IDLE,
		IO_REQ,
		IO_WAIT,
		IO_DONE
	} ioState_t;

endpackage

/* rtl/chipSelect.sv */
`timescale 1ns/1ns

module chipSelect (
	input logic CLK_FSB,
	input logic arstN,
	input logic bAct,
	input fsbPkg::fsbCycle_t cyc,
	input logic romIo,
	input logic accDis,
	output ctlPkg::devSel_t sel
);
	import fsbPkg::*;
	import ctlPkg::*;

	fsbAddr_t addr;
	logic ramArea;
	logic sndArea;
	logic romArea;
	logic scsiArea;
	logic iaArea;
	logic otherArea;
	devSel_t selNext;

	// addr[i] carries A[i+1]
	assign addr = cyc.addr;

	// 0x000000-0x3FFFFF
	assign ramArea = (addr[22:21] == 2'b00);
	// top of RAM from 0x3FA000 holds the sound buffer
	assign sndArea = ramArea && (addr[20:11] >= 10'h3FA);
	// 0x400000-0x4FFFFF
	assign romArea = (addr[22:19] == 4'h4);
	// 0x580000-0x5FFFFF
	assign scsiArea = (addr[22:18] == 5'b01011);
	// interrupt acknowledge space
	assign iaArea = (addr[22:19] == 4'hF);
	assign otherArea = !ramArea && !romArea && !scsiArea && !iaArea;

	always_comb begin
		selNext.ramCs = ramArea && !accDis;
		selNext.romCs = romArea && !romIo;
		selNext.scsiCs = scsiArea;
		selNext.iaCs = iaArea;
		selNext.sndWrCs = sndArea && !accDis && !cyc.nWe;
		// SCSI, rerouted ROM and RAM of a disabled card all go to the I/O bus
		selNext.ioCs = otherArea || scsiArea || (romArea && romIo) ||
			(ramArea && accDis);
	end

	// sample while idle so the selects hold still for the whole cycle
	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			sel <= '0;
		end else if (!bAct) begin
			sel <= selNext;
		end
	end

endmodule

/* rtl/cycleTimer.sv */
`timescale 1ns/1ns
`include "warp_defs.svh"

module cycleTimer (
	input logic CLK_FSB,
	input logic arstN,
	input logic bAct,
	output logic tmoA,
	output logic tmoB
);
	typedef logic [`WARP_CNT_W-1:0] cycCnt_t;

	localparam int tmoALen = `WARP_TMO_A;
	localparam int tmoBLen = `WARP_TMO_B;

	cycCnt_t cnt;

	// saturating count of active cycles
	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			cnt <= '0;
		end else if (!bAct) begin
			cnt <= '0;
		end else if (cnt != '1) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			tmoA <= 1'b0;
			tmoB <= 1'b0;
		end else begin
			tmoA <= bAct && (int'(cnt) >= tmoALen);
			tmoB <= bAct && (int'(cnt) >= tmoBLen);
		end
	end

endmodule

/* rtl/ioSlave.sv */
`timescale 1ns/1ns

module ioSlave (
	input logic CLK_FSB,
	input logic arstN,
	input logic bAct,
	input fsbPkg::fsbCycle_t cyc,
	input logic ioCs,
	input logic ioAct,
	input logic ioBerr,
	output logic ioReq,
	output logic ioRw,
	output logic ioLds,
	output logic ioUds,
	output logic ioReady,
	output logic ioBerrOut
);
	import ctlPkg::*;

	ioState_t state;
	logic [1:0] actSync;
	logic [1:0] berrSync;
	logic sawAct;

	// master handshake is brought in through two flops
	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			actSync <= '0;
			berrSync <= '0;
		end else begin
			actSync <= {actSync[0], ioAct};
			berrSync <= {berrSync[0], ioBerr};
		end
	end

	// request lasts exactly the one cycle spent in IO_REQ
	assign ioReq = (state == IO_REQ);

	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			state <= IO_IDLE;
			sawAct <= 1'b0;
			ioReady <= 1'b0;
			ioBerrOut <= 1'b0;
			ioRw <= 1'b1;
			ioLds <= 1'b0;
			ioUds <= 1'b0;
		end else begin
			case (state)
				IO_IDLE: begin
					sawAct <= 1'b0;
					if (bAct && ioCs) begin
						state <= IO_REQ;
						// ioRw high for reads, byte strobes active high
						ioRw <= cyc.nWe;
						ioLds <= !cyc.nLds;
						ioUds <= !cyc.nUds;
					end
				end
				IO_REQ: begin
					state <= IO_WAIT;
				end
				IO_WAIT: begin
					if (actSync[1]) begin
						sawAct <= 1'b1;
					end
					if (berrSync[1]) begin
						state <= IO_DONE;
						ioBerrOut <= 1'b1;
					end else if (sawAct && !actSync[1]) begin
						// master finished on the falling edge of ioAct
						state <= IO_DONE;
						ioReady <= 1'b1;
					end
				end
				IO_DONE: begin
					if (!bAct) begin
						state <= IO_IDLE;
						ioReady <= 1'b0;
						ioBerrOut <= 1'b0;
					end
				end
				default: state <= IO_IDLE;
			endcase
		end
	end

endmodule

/* rtl/disableCtl.sv */
`timescale 1ns/1ns

module disableCtl (
	input logic CLK_FSB,
	input logic arstN,
	input logic nRES,
	input logic nIPL2,
	output logic accDis
);
	// newest sample in bit 0
	logic [2:0] resSync;
	logic [1:0] iplSync;
	logic resDone;
	logic resRelease;

	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			resSync <= '0;
			iplSync <= '0;
		end else begin
			resSync <= {resSync[1:0], !nRES};
			iplSync <= {iplSync[0], !nIPL2};
		end
	end

	// reset seen, then two clean samples without it
	assign resRelease = !resSync[0] && !resSync[1] && resSync[2];

	// only the first reset after power-up may disable the card
	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			resDone <= 1'b0;
			accDis <= 1'b0;
		end else begin
			if (&resSync && &iplSync && !resDone) begin
				accDis <= 1'b1;
			end
			if (resRelease) begin
				resDone <= 1'b1;
			end
		end
	end

endmodule

/* rtl/fsbResponder.sv */
`timescale 1ns/1ns

module fsbResponder (
	input logic CLK_FSB,
	input logic arstN,
	input fsbPkg::fsbCycle_t cyc,
	input ctlPkg::devSel_t sel,
	input logic tmoA,
	input logic tmoB,
	input logic ioReady,
	input logic ioBerrOut,
	output logic bAct,
	output logic nDTACK,
	output logic nVPA,
	output logic nBERR
);
	logic act;
	logic localRdy;
	logic rdy;
	logic berr;
	logic answered;

	// AS registered on the bus clock
	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			bAct <= 1'b0;
		end else begin
			bAct <= !cyc.nAs;
		end
	end

	// AS rising ends the cycle on the next edge
	assign act = bAct && !cyc.nAs;

	// sound RAM writes wait for timeout A
	assign localRdy = (sel.ramCs || sel.romCs) && !(sel.sndWrCs && !tmoA);
	assign rdy = localRdy || ioReady;
	// SCSI may stretch its cycle indefinitely
	assign berr = ioBerrOut || (tmoB && !sel.scsiCs);
	assign answered = !nDTACK || !nVPA || !nBERR;

	always_ff @(posedge CLK_FSB or negedge arstN) begin
		if (!arstN) begin
			nDTACK <= 1'b1;
			nVPA <= 1'b1;
			nBERR <= 1'b1;
		end else if (!act) begin
			nDTACK <= 1'b1;
			nVPA <= 1'b1;
			nBERR <= 1'b1;
		end else if (!answered) begin
			// first response wins and is held to the end of the cycle
			if (berr) begin
				nBERR <= 1'b0;
			end else if (sel.iaCs) begin
				nVPA <= 1'b0;
			end else if (rdy) begin
				nDTACK <= 1'b0;
			end
		end
	end

endmodule

/* rtl/warpBus.sv */
`timescale 1ns/1ns
`include "warp_defs.svh"

module warpBus (
	input logic CLK_FSB,
	input logic arstN,
	input logic [`WARP_ADDR_W:1] A_FSB,
	input logic nAS_FSB,
	input logic nLDS_FSB,
	input logic nUDS_FSB,
	input logic nWE_FSB,
	input logic nRES,
	input logic nIPL2,
	input logic [1:0] sw,
	input logic ioAct,
	input logic ioBerr,
	output logic nDTACK_FSB,
	output logic nVPA_FSB,
	output logic nBERR_FSB,
	output logic ioReq,
	output logic ioRw,
	output logic ioLds,
	output logic ioUds
);
	import fsbPkg::*;
	import ctlPkg::*;

	fsbCycle_t cyc;
	devSel_t sel;
	logic bAct;
	logic tmoA;
	logic tmoB;
	logic ioReady;
	logic ioBerrOut;
	logic accDis;

	assign cyc = '{addr: A_FSB, nAs: nAS_FSB, nLds: nLDS_FSB, nUds: nUDS_FSB,
		nWe: nWE_FSB};

	// sw[1] moves ROM onto the motherboard, sw[0] was the oscillator select
	chipSelect i_chipSelect (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .bAct(bAct), .cyc(cyc),
		.romIo(sw[1]), .accDis(accDis), .sel(sel)
	);

	cycleTimer i_cycleTimer (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .bAct(bAct), .tmoA(tmoA), .tmoB(tmoB)
	);

	ioSlave i_ioSlave (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .bAct(bAct), .cyc(cyc), .ioCs(sel.ioCs),
		.ioAct(ioAct), .ioBerr(ioBerr), .ioReq(ioReq), .ioRw(ioRw), .ioLds(ioLds),
		.ioUds(ioUds), .ioReady(ioReady), .ioBerrOut(ioBerrOut)
	);

	disableCtl i_disableCtl (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .nRES(nRES), .nIPL2(nIPL2), .accDis(accDis)
	);

	fsbResponder i_fsbResponder (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .cyc(cyc), .sel(sel), .tmoA(tmoA),
		.tmoB(tmoB), .ioReady(ioReady), .ioBerrOut(ioBerrOut), .bAct(bAct),
		.nDTACK(nDTACK_FSB), .nVPA(nVPA_FSB), .nBERR(nBERR_FSB)
	);

endmodule

/* tests/warpBus_props.sv */
`timescale 1ns/1ns

module warpBus_props (
	input logic CLK_FSB,
	input logic arstN,
	input fsbPkg::fsbCycle_t cyc,
	input logic nDTACK,
	input logic nVPA,
	input logic nBERR,
	input logic ioReq
);
	logic [2:0] rsp;

	assign rsp = {nDTACK, nVPA, nBERR};

	// DTACK, VPA and BERR never overlap
	singleResponse: assert property (
		@(posedge CLK_FSB) disable iff (!arstN) $onehot0(~rsp)
	) else $error("more than one bus response asserted: %b", rsp);

	// responses are gone one edge after AS
	idleResponse: assert property (
		@(posedge CLK_FSB) disable iff (!arstN) cyc.nAs |=> (rsp == 3'b111)
	) else $error("bus response asserted without AS");

	reqPulse: assert property (
		@(posedge CLK_FSB) disable iff (!arstN) $rose(ioReq) |=> !ioReq
	) else $error("ioReq held longer than one clock");

	// first edge out of reset gives no response
	resetIdle: assert property (
		@(posedge CLK_FSB) $rose(arstN) |=> (rsp == 3'b111)
	) else $error("bus response asserted right after reset");

endmodule

// ioReq comes from the enclosing top level
bind fsbResponder warpBus_props i_warpBusProps (
	.CLK_FSB(CLK_FSB), .arstN(arstN), .cyc(cyc), .nDTACK(nDTACK), .nVPA(nVPA),
	.nBERR(nBERR), .ioReq(warpBus.ioReq)
);

/* tests/warpBus_tb.sv */
`timescale 1ns/1ns
`include "warp_defs.svh"

module warpBus_tb;
	// what the I/O master does once it sees ioReq
	typedef enum logic [1:0] {ACT_NONE, ACT_ANSWER, ACT_BERR, ACT_LATE} masterAct_t;

	// rsp is the expected {nDTACK, nVPA, nBERR}
	// strb is {uds, lds} active high
	typedef struct packed {
		logic [23:0] addr;
		logic wr;
		logic [1:0] strb;
		logic [1:0] sw;
		masterAct_t act;
		logic [2:0] rsp;
		logic req;
		logic [8:0] minLat;
		logic [8:0] maxLat;
	} tblEntry_t;

	localparam logic [2:0] RSP_DTACK = 3'b011;
	localparam logic [2:0] RSP_VPA = 3'b101;
	localparam logic [2:0] RSP_BERR = 3'b110;
	localparam logic [2:0] RSP_NONE = 3'b111;
	localparam int clkPeriod = 40;
	localparam int mainLen = 15;
	localparam int tableLen = 18;
	localparam int resetCycles = 24;
	localparam int lateStart = 2 * `WARP_TMO_B + 1;
	localparam int watchdogTime = tableLen * (`WARP_TMO_B + 20) * clkPeriod +
		3 * resetCycles * clkPeriod;

	logic CLK_FSB;
	logic arstN;
	logic [23:1] A_FSB;
	logic nAS_FSB, nLDS_FSB, nUDS_FSB, nWE_FSB;
	logic nRES, nIPL2;
	logic [1:0] sw;
	logic ioAct, ioBerr;
	logic nDTACK_FSB, nVPA_FSB, nBERR_FSB;
	logic ioReq, ioRw, ioLds, ioUds;

	tblEntry_t tbl [tableLen];
	int tblFill;
	int errCount;
	logic [31:0] lcgState;

	warpBus i_warpBus (
		.CLK_FSB(CLK_FSB), .arstN(arstN), .A_FSB(A_FSB), .nAS_FSB(nAS_FSB),
		.nLDS_FSB(nLDS_FSB), .nUDS_FSB(nUDS_FSB), .nWE_FSB(nWE_FSB), .nRES(nRES),
		.nIPL2(nIPL2), .sw(sw), .ioAct(ioAct), .ioBerr(ioBerr), .nDTACK_FSB(nDTACK_FSB),
		.nVPA_FSB(nVPA_FSB), .nBERR_FSB(nBERR_FSB), .ioReq(ioReq), .ioRw(ioRw),
		.ioLds(ioLds), .ioUds(ioUds)
	);

	always #(clkPeriod / 2) CLK_FSB = !CLK_FSB;

	task automatic stopRun(input string why);
		errCount++;
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stopRun($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic addEntry(input logic [23:0] addr, input logic wr, input logic [1:0] strb,
		input logic [1:0] swVal, input masterAct_t act, input logic [2:0] rsp,
		input logic req, input logic [8:0] minLat, input logic [8:0] maxLat);
		tbl[tblFill] = '{addr, wr, strb, swVal, act, rsp, req, minLat, maxLat};
		tblFill++;
	endtask

	task automatic buildTable();
		// local RAM and ROM answer on the second edge
		addEntry(24'h012340, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		addEntry(24'h3F0000, 1'b1, 2'b01, 2'b00, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		addEntry(24'h3FA100, 1'b1, 2'b11, 2'b00, ACT_NONE, RSP_DTACK, 1'b0,
			`WARP_TMO_A, `WARP_TMO_A + 4);
		addEntry(24'h3FC000, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		addEntry(24'h400100, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		addEntry(24'h000100, 1'b1, 2'b10, 2'b10, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		// motherboard cycles through the I/O port
		addEntry(24'h4000F0, 1'b0, 2'b11, 2'b10, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
		addEntry(24'hEFE1FE, 1'b0, 2'b10, 2'b00, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
		addEntry(24'hDFE1FE, 1'b1, 2'b01, 2'b00, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
		addEntry(24'h580000, 1'b1, 2'b11, 2'b00, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
		addEntry(24'hC00000, 1'b0, 2'b11, 2'b00, ACT_BERR, RSP_BERR, 1'b1, 4, 24);
		addEntry(24'h5800F0, 1'b0, 2'b11, 2'b00, ACT_BERR, RSP_BERR, 1'b1, 4, 24);
		addEntry(24'h800000, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_BERR, 1'b1,
			`WARP_TMO_B, `WARP_TMO_B + 6);
		addEntry(24'h580010, 1'b0, 2'b11, 2'b00, ACT_LATE, RSP_DTACK, 1'b1,
			2 * `WARP_TMO_B, 2 * `WARP_TMO_B + 20);
		addEntry(24'hFFFFF2, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_VPA, 1'b0, 1, 1);
		// disable latch phases
		addEntry(24'h020000, 1'b0, 2'b11, 2'b00, ACT_NONE, RSP_DTACK, 1'b0, 1, 1);
		addEntry(24'h020000, 1'b0, 2'b11, 2'b00, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
		addEntry(24'h3FB000, 1'b1, 2'b11, 2'b00, ACT_ANSWER, RSP_DTACK, 1'b1, 4, 24);
	endtask

	task automatic busIdle();
		A_FSB = '0;
		nAS_FSB = 1'b1;
		nLDS_FSB = 1'b1;
		nUDS_FSB = 1'b1;
		nWE_FSB = 1'b1;
	endtask

	// power-up reset with nRES held low a while after arstN
	task automatic applyReset(input logic iplLow);
		#2;
		arstN = 1'b0;
		nRES = 1'b0;
		nIPL2 = !iplLow;
		ioAct = 1'b0;
		ioBerr = 1'b0;
		busIdle();
		repeat (10) @(posedge CLK_FSB);
		#2;
		arstN = 1'b1;
		repeat (6) @(posedge CLK_FSB);
		#2;
		nRES = 1'b1;
		nIPL2 = 1'b1;
		repeat (6) @(posedge CLK_FSB);
		@(negedge CLK_FSB);
		checkValue("responses", {nDTACK_FSB, nVPA_FSB, nBERR_FSB}, RSP_NONE);
		checkValue("ioReq", ioReq, 1'b0);
	endtask

	task automatic pulseReset(input logic iplLow);
		@(posedge CLK_FSB);
		#2;
		nRES = 1'b0;
		nIPL2 = !iplLow;
		repeat (8) @(posedge CLK_FSB);
		#2;
		nRES = 1'b1;
		nIPL2 = 1'b1;
		repeat (6) @(posedge CLK_FSB);
	endtask

	task automatic runEntry(input int idx);
		tblEntry_t e;
		int edges;
		int lat;
		int reqCount;
		int holdLeft;
		int mstPhase;
		int mstDelay;
		logic [2:0] rsp;
		logic gotRsp;
		e = tbl[idx];
		mstDelay = 1 + int'(nextRand() >> 16) % 5;
		edges = 0;
		lat = 0;
		reqCount = 0;
		holdLeft = 0;
		mstPhase = 0;
		gotRsp = 1'b0;
		@(posedge CLK_FSB);
		#2;
		sw = e.sw;
		A_FSB = e.addr[23:1];
		nWE_FSB = !e.wr;
		nUDS_FSB = !e.strb[1];
		nLDS_FSB = !e.strb[0];
		nAS_FSB = 1'b0;
		while (!gotRsp) begin
			@(posedge CLK_FSB);
			edges++;
			#2;
			// master drives from what it saw at the last falling edge
			if (mstPhase == 1) begin
				if (e.act == ACT_BERR) begin
					ioBerr = 1'b1;
					mstPhase = 2;
				end else if (e.act == ACT_ANSWER || (e.act == ACT_LATE && edges > lateStart)) begin
					ioAct = 1'b1;
					holdLeft--;
					if (holdLeft == 0)
						mstPhase = 2;
				end
			end else if (mstPhase == 2) begin
				ioAct = 1'b0;
				ioBerr = 1'b0;
			end
			@(negedge CLK_FSB);
			rsp = {nDTACK_FSB, nVPA_FSB, nBERR_FSB};
			if (ioReq === 1'b1) begin
				reqCount++;
				checkValue("ioRw", ioRw, !e.wr);
				checkValue("ioUds", ioUds, e.strb[1]);
				checkValue("ioLds", ioLds, e.strb[0]);
				if (mstPhase == 0) begin
					mstPhase = 1;
					holdLeft = mstDelay;
				end
			end
			if (rsp !== RSP_NONE) begin
				gotRsp = 1'b1;
				lat = edges - 1;
			end else if (edges > e.maxLat + 2) begin
				stopRun($sformatf("no response to the cycle at 0x%06h within %0d clocks",
					e.addr, edges));
			end
		end
		checkValue("responses", rsp, e.rsp);
		checkValue("ioReq pulses", reqCount, e.req);
		if (e.req) begin
			checkValue("ioRw held", ioRw, !e.wr);
			checkValue("ioUds held", ioUds, e.strb[1]);
			checkValue("ioLds held", ioLds, e.strb[0]);
		end
		if (lat < e.minLat || lat > e.maxLat) begin
			stopRun($sformatf("cycle at 0x%06h answered after %0d clocks, allowed %0d to %0d",
				e.addr, lat, e.minLat, e.maxLat));
		end
		@(posedge CLK_FSB);
		#2;
		busIdle();
		ioAct = 1'b0;
		ioBerr = 1'b0;
		@(posedge CLK_FSB);
		@(negedge CLK_FSB);
		checkValue("responses after AS", {nDTACK_FSB, nVPA_FSB, nBERR_FSB}, RSP_NONE);
		// a silent master still finishes its access, which frees the slave port
		if (e.act == ACT_NONE && e.req) begin
			@(posedge CLK_FSB);
			#2;
			ioAct = 1'b1;
			repeat (2) @(posedge CLK_FSB);
			#2;
			ioAct = 1'b0;
		end
		repeat (6) @(posedge CLK_FSB);
	endtask

	initial begin
		CLK_FSB = 1'b0;
		errCount = 0;
		tblFill = 0;
		lcgState = 32'hc422_ed04;
		arstN = 1'b0;
		nRES = 1'b0;
		nIPL2 = 1'b1;
		sw = 2'b00;
		ioAct = 1'b0;
		ioBerr = 1'b0;
		busIdle();
		buildTable();
		if (tblFill != tableLen)
			stopRun("stimulus table does not hold the expected number of entries");
		applyReset(1'b0);
		for (int i = 0; i < mainLen; i++)
			runEntry(i);
		// IPL2 low on a later reset leaves the card enabled
		pulseReset(1'b1);
		runEntry(mainLen);
		// IPL2 low through the power-up reset sends RAM to the motherboard
		applyReset(1'b1);
		runEntry(mainLen + 1);
		runEntry(mainLen + 2);
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#(watchdogTime);
		stopRun("watchdog expired before the tests finished");
	end

endmodule

/* files.f */
+incdir+rtl
rtl/fsbPkg.sv
rtl/ctlPkg.sv
rtl/chipSelect.sv
rtl/cycleTimer.sv
rtl/ioSlave.sv
rtl/disableCtl.sv
rtl/fsbResponder.sv
rtl/warpBus.sv
tests/warpBus_props.sv
tests/warpBus_tb.sv
